/* Makefile */
VERILATOR ?= verilator
TOP       := tb_rdma_meta_rx
FILELIST  := tb.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
	  echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/clk_gen.sv */
`timescale 1ns/1ps

// Free running clock for the testbench
module clk_gen (
  output logic aclk
);

  // 100 ns period starting low
  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

endmodule

/* dv/rx_meta_stimulus.txt */
# t: test number and name | r: opcode qpn len region (hex), waits for acceptance
# s: opcode qpn len region cycles, stalls on a full queue, then all m_ready go high
# d: m_ready mask and idle cycles | x: random m_ready idle cycles | z: reset
t 1 decode
d f 1
r 0 000005 00040 0
r 1 123447 00100 1
r 2 abcd9c 00fff 2
r 3 fffff1 fffff 3
r 1 0000c0 00001 3
d f 4
t 2 partial_drain
d 5 1
r 0 000a10 00010 0
r 1 000b50 00020 1
r 2 000c90 00030 2
r 3 000dd0 00040 3
d 5 4
d f 4
t 3 order
d 0 1
r 0 100001 00001 0
r 0 200002 00002 0
r 2 300083 00003 2
r 1 400044 00004 1
r 0 500005 00005 0
r 3 6000c6 00006 3
r 2 700087 00007 2
r 3 8000c8 00008 3
d f 6
t 4 stall
d e 1
r 0 010001 00011 0
r 1 010002 00012 0
r 2 010003 00013 0
r 3 010004 00014 0
r 0 010005 00015 0
r 1 010006 00016 0
r 2 010007 00017 0
r 3 010008 00018 0
s 1 010009 00019 0 6
d f 12
t 5 random
x 3
r 2 000041 00010 1
r 0 0000ff 00020 3
r 1 000080 00030 2
r 3 00003f 00040 0
r 2 0001c1 00050 3
r 0 000042 00060 1
x 24
d f 8
z

/* dv/tb_rdma_meta_rx.sv */
`timescale 1ns/1ps

module tb_rdma_meta_rx;

  localparam string stim_file = "dv/rx_meta_stimulus.txt";

  logic                                                aclk;
  logic                                                rst_n;
  logic                                                s_valid;
  logic                                                s_ready;
  rdma_rx_pkg::rdma_req_t                              s_data;
  logic [rdma_rx_pkg::n_regions-1:0]                   m_valid;
  logic [rdma_rx_pkg::n_regions-1:0]                   m_ready;
  rdma_rx_pkg::rdma_req_t [rdma_rx_pkg::n_regions-1:0] m_data;
  logic [rdma_rx_pkg::n_regions_bits-1:0]              vfid;

  // Expected contents of each region queue
  rdma_rx_pkg::rdma_req_t model_q [rdma_rx_pkg::n_regions][$];

  // Parsed stimulus with one entry per command line
  byte   cmd_kind [$];
  int    cmd_a [$];
  int    cmd_b [$];
  int    cmd_c [$];
  int    cmd_d [$];
  int    cmd_e [$];
  string cmd_name [$];

  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    test_num = 0;
  int    test_err_start = 0;
  string test_name = "";
  int    limit_cycles = 0;

  // Source of m_ready as a fixed mask or random per cycle
  logic [rdma_rx_pkg::n_regions-1:0] ready_mask = '1;
  bit                                random_ready = 1'b0;

  clk_gen inst_clk (.aclk(aclk));

  rdma_meta_rx_top UUT (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .vfid    (vfid)
  );

  // Owning region is qpn bits 7 to 6
  function automatic int region_of(input rdma_rx_pkg::rdma_req_t r);
    return int'(r.qpn[7:6]);
  endfunction

  // Checker sampling the values present just before the edge
  always @(posedge aclk) begin : monitor
    rdma_rx_pkg::rdma_req_t exp;
    if (rst_n) begin
      for (int i = 0; i < rdma_rx_pkg::n_regions; i++) begin
        // Valid one cycle after a push into an empty queue
        checks++;
        assert (m_valid[i] == (model_q[i].size() != 0)) else begin
          $display("error at %0d ns: m_valid[%0d] = %b, expected %b", $time, i,
                   m_valid[i], model_q[i].size() != 0);
          errors++;
        end
        if (m_valid[i] && m_ready[i] && model_q[i].size() != 0) begin
          exp = model_q[i].pop_front();
          checks++;
          assert (m_data[i] == exp) else begin
            $display("error at %0d ns: m_data[%0d] = %h, expected %h", $time, i, m_data[i], exp);
            errors++;
          end
        end
      end
      if (s_valid) begin
        checks++;
        assert (vfid == s_data.qpn[7:6]) else begin
          $display("error at %0d ns: vfid = %0d, expected %0d", $time, vfid, s_data.qpn[7:6]);
          errors++;
        end
        // Accepted request goes to its own region model
        if (s_ready) begin
          model_q[region_of(s_data)].push_back(s_data);
        end
      end
    end
  end

  // Ends a hung run once the stimulus has set the limit
  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge aclk);
    $display("timeout after %0d cycles, the DUT stopped making progress", limit_cycles);
    $display("TB FAILED");
    $finish;
  end

  task automatic load_stimulus();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    int    d;
    int    e;
    int    total;
    string line;
    string word;
    string name;
    total = 0;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", stim_file);
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", word);
        if (n == 1 && word[0] != "#") begin
          a = 0;
          b = 0;
          c = 0;
          d = 0;
          e = 0;
          name = "";
          if (word[0] == "t") n = $sscanf(line, "%s %d %s", word, a, name);
          else n = $sscanf(line, "%s %h %h %h %h %h", word, a, b, c, d, e);
          cmd_kind.push_back(word[0]);
          cmd_a.push_back(a);
          cmd_b.push_back(b);
          cmd_c.push_back(c);
          cmd_d.push_back(d);
          cmd_e.push_back(e);
          cmd_name.push_back(name);
          // Cycle budget of each command
          case (word[0])
            "r":     total += 1;
            "s":     total += e + 1;
            "d":     total += b;
            "x":     total += a;
            "z":     total += 6;
            default: total += 0;
          endcase
        end
      end
      $fclose(fd);
    end
    limit_cycles = total * 4 + 200;
  endtask

  task automatic set_ready();
    logic [31:0] rnd;
    rnd = $urandom();
    if (random_ready) m_ready = rnd[rdma_rx_pkg::n_regions-1:0];
    else m_ready = ready_mask;
  endtask

  task automatic apply_reset();
    s_valid = 1'b0;
    m_ready = '0;
    random_ready = 1'b0;
    rst_n = 1'b0;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    // Idle outputs out of reset
    checks += 2;
    assert (m_valid == '0) else begin
      $display("error at %0d ns: m_valid = %b, expected 0", $time, m_valid);
      errors++;
    end
    assert (s_ready) else begin
      $display("error at %0d ns: s_ready = %b, expected 1", $time, s_ready);
      errors++;
    end
    for (int i = 0; i < rdma_rx_pkg::n_regions; i++) model_q[i].delete();
    rst_n = 1'b1;
  endtask

  task automatic check_region(input rdma_rx_pkg::rdma_req_t req, input int region);
    checks++;
    assert (region == region_of(req)) else begin
      $display("error at %0d ns: stimulus region = %0d, expected %0d", $time, region,
               region_of(req));
      errors++;
    end
  endtask

  // Holds the request until the DUT takes it
  task automatic wait_accept();
    bit done;
    done = 1'b0;
    while (!done) begin
      @(posedge aclk);
      done = s_ready;
      @(negedge aclk);
      set_ready();
    end
    s_valid = 1'b0;
  endtask

  task automatic send_request(input rdma_rx_pkg::rdma_req_t req, input int region);
    check_region(req, region);
    s_data = req;
    s_valid = 1'b1;
    wait_accept();
  endtask

  // Request against a full queue until m_ready is raised to free it
  task automatic hold_stalled(input rdma_rx_pkg::rdma_req_t req, input int region,
                              input int n);
    check_region(req, region);
    s_data = req;
    s_valid = 1'b1;
    repeat (n) begin
      @(posedge aclk);
      checks++;
      assert (!s_ready) else begin
        $display("error at %0d ns: s_ready = %b, expected 0", $time, s_ready);
        errors++;
      end
      @(negedge aclk);
      set_ready();
    end
    checks++;
    assert (model_q[region].size() == int'(rdma_rx_pkg::queue_depth)) else begin
      $display("stall came with %0d requests queued for region %0d instead of a full queue",
               model_q[region].size(), region);
      errors++;
    end
    ready_mask = '1;
    random_ready = 1'b0;
    set_ready();
    wait_accept();
  endtask

  task automatic run_idle(input int n);
    s_valid = 1'b0;
    set_ready();
    repeat (n) begin
      @(negedge aclk);
      set_ready();
    end
  endtask

  // Every accepted request must be out of the DUT by now
  task automatic check_drained();
    for (int i = 0; i < rdma_rx_pkg::n_regions; i++) begin
      checks++;
      assert (model_q[i].size() == 0) else begin
        $display("region %0d still holds %0d undelivered requests", i, model_q[i].size());
        errors++;
      end
    end
  endtask

  // Reports the test that just ran
  task automatic end_test();
    if (test_num != 0) begin
      check_drained();
      $display("test %0d %s: %0d errors", test_num, test_name, errors - test_err_start);
      tests++;
    end
  endtask

  initial begin : main
    rdma_rx_pkg::rdma_req_t req;
    int a;
    int b;
    int c;
    rst_n = 1'b0;
    s_valid = 1'b0;
    s_data = '0;
    m_ready = '0;
    void'($urandom(32'hcad4));
    load_stimulus();
    apply_reset();
    for (int k = 0; k < cmd_kind.size(); k++) begin
      a = cmd_a[k];
      b = cmd_b[k];
      c = cmd_c[k];
      req.opcode = rdma_rx_pkg::rdma_opcode_e'(a[3:0]);
      req.qpn = b[rdma_rx_pkg::qpn_bits-1:0];
      req.len = c[rdma_rx_pkg::len_bits-1:0];
      case (cmd_kind[k])
        "t": begin
          end_test();
          test_num = a;
          test_name = cmd_name[k];
          test_err_start = errors;
        end
        "r": send_request(req, cmd_d[k]);
        "s": hold_stalled(req, cmd_d[k], cmd_e[k]);
        "d": begin
          ready_mask = a[rdma_rx_pkg::n_regions-1:0];
          random_ready = 1'b0;
          run_idle(b);
        end
        "x": begin
          random_ready = 1'b1;
          run_idle(a);
        end
        "z": begin
          // Reset flushes the queues, so delivery is settled first
          check_drained();
          apply_reset();
        end
        default: begin
          $display("unknown stimulus command at entry %0d", k);
          errors++;
        end
      endcase
    end
    end_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* source/meta_if.sv */
`timescale 1ns/1ps

// Request metadata stream with valid/ready handshake
interface meta_if;

  // Source holds data while valid is up and ready is down
  logic                   valid;
  logic                   ready;
  rdma_rx_pkg::rdma_req_t data;

  // Producer side
  modport source (
    output valid,
    output data,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* source/rdma_meta_rx_top.sv */
`timescale 1ns/1ps

module rdma_meta_rx_top (
  input  logic                                                 aclk,
  input  logic                                                 rst_n,

  // Request descriptor input
  input  logic                                                 s_valid,
  output logic                                                 s_ready,
  input  rdma_rx_pkg::rdma_req_t                               s_data,

  // Per region request outputs
  output logic [rdma_rx_pkg::n_regions-1:0]                    m_valid,
  input  logic [rdma_rx_pkg::n_regions-1:0]                    m_ready,
  output rdma_rx_pkg::rdma_req_t [rdma_rx_pkg::n_regions-1:0]  m_data,

  // Owning region of the request on s_data
  output logic [rdma_rx_pkg::n_regions_bits-1:0]               vfid
);

  // Steering to queue links, one per region
  meta_if q_if [rdma_rx_pkg::n_regions] ();

  // Region decode and input handshake
  rx_meta_steer inst_steer (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .q       (q_if),
    .vfid    (vfid)
  );

  // One queue per user region
  // each drains on its own stream
  for (genvar i = 0; i < rdma_rx_pkg::n_regions; i++) begin : g_queue
    region_queue inst_rx_queue (
      .aclk    (aclk),
      .rst_n   (rst_n),
      .s       (q_if[i]),
      .m_valid (m_valid[i]),
      .m_ready (m_ready[i]),
      .m_data  (m_data[i])
    );
  end

endmodule

/* source/rdma_rx_pkg.sv */
package rdma_rx_pkg;

  // Number of user regions sharing the receive path
  localparam int unsigned n_regions = 4;
  // Width of a region index
  localparam int unsigned n_regions_bits = 2;

  // Low qpn bits that sit below the region field
  localparam int unsigned pid_bits = 6;

  // Entries held by each region queue
  localparam int unsigned queue_depth = 8;
  // Read and write pointer width
  localparam int unsigned queue_ptr_bits = $clog2(queue_depth);
  // Occupancy counter must also hold the full value
  localparam int unsigned queue_cnt_bits = queue_ptr_bits + 1;
  // Occupancy value that marks a full queue
  localparam logic [queue_cnt_bits-1:0] queue_full_cnt = queue_cnt_bits'(queue_depth);

  // Request field widths
  localparam int unsigned qpn_bits = 24;
  localparam int unsigned len_bits = 20;

  // RDMA operation carried by a request
  typedef enum logic [3:0] {
    op_read  = 4'h0,
    op_write = 4'h1,
    op_send  = 4'h2,
    op_ack   = 4'h3
  } rdma_opcode_e;

  // Request descriptor of 48 bits in total
  // Opcode in the top nibble and length in the low bits
  typedef struct packed {
    rdma_opcode_e          opcode;
    logic [qpn_bits-1:0]   qpn;
    logic [len_bits-1:0]   len;
  } rdma_req_t;

endpackage

/* source/region_queue.sv */
`timescale 1ns/1ps

module region_queue (
  input  logic                   aclk,
  input  logic                   rst_n,

  // Requests steered to this region
  meta_if.sink                   s,

  // Drain side toward the user region
  output logic                   m_valid,
  input  logic                   m_ready,
  output rdma_rx_pkg::rdma_req_t m_data
);

  // Entry storage
  rdma_rx_pkg::rdma_req_t mem [rdma_rx_pkg::queue_depth];

  // Circular buffer pointers
  logic [rdma_rx_pkg::queue_ptr_bits-1:0] wr_ptr;
  logic [rdma_rx_pkg::queue_ptr_bits-1:0] rd_ptr;
  // Number of entries held
  logic [rdma_rx_pkg::queue_cnt_bits-1:0] count;

  // Handshake strobes
  logic push;
  logic pop;
  logic full;

  // Full at queue_depth entries
  assign full = (count == rdma_rx_pkg::queue_full_cnt);

  // Accept whenever there is room
  assign s.ready = !full;
  // Head entry visible while not empty
  assign m_valid = (count != '0);
  assign m_data  = mem[rd_ptr];

  // Transfers on both sides
  assign push = s.valid && !full;
  assign pop  = m_valid && m_ready;

  // Write port
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s.data;
    end
  end

  // Pointers and occupancy
  // Depth is a power of two so pointers wrap by themselves
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy bounded by the depth
  a_count_bound : assert property (
    @(posedge aclk) disable iff (!rst_n)
    count <= rdma_rx_pkg::queue_full_cnt
  ) else $error("region_queue: count above queue_depth");

  // Output valid only falls after a pop
  a_valid_drop : assert property (
    @(posedge aclk) disable iff (!rst_n)
    $fell(m_valid) |-> $past(pop)
  ) else $error("region_queue: m_valid dropped without a pop");

  // Blocked head entry is held in place
  a_head_hold : assert property (
    @(posedge aclk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data))
  ) else $error("region_queue: head entry changed while blocked");

endmodule

/* source/rx_meta_steer.sv */
`timescale 1ns/1ps

module rx_meta_steer (
  input  logic                                   aclk,
  input  logic                                   rst_n,

  // Incoming request stream
  input  logic                                   s_valid,
  output logic                                   s_ready,
  input  rdma_rx_pkg::rdma_req_t                 s_data,

  // One stream toward each region queue
  meta_if.source                                 q [rdma_rx_pkg::n_regions],

  // Region that owns the current request
  output logic [rdma_rx_pkg::n_regions_bits-1:0] vfid
);

  // Per region valid and ready, gathered for indexing
  logic [rdma_rx_pkg::n_regions-1:0] q_valid;
  logic [rdma_rx_pkg::n_regions-1:0] q_ready;

  // Region field sits just above the pid bits of the qpn
  assign vfid = s_data.qpn[rdma_rx_pkg::pid_bits +: rdma_rx_pkg::n_regions_bits];

  // One-hot steer of the input valid
  // Shift a single valid bit up to the owning region
  assign q_valid = {{(rdma_rx_pkg::n_regions-1){1'b0}}, s_valid} << vfid;

  // Only the owning queue can accept
  // so a full target stalls the whole input (head-of-line blocking)
  assign s_ready = q_ready[vfid];

  // Fan out to the queue interfaces
  for (genvar i = 0; i < rdma_rx_pkg::n_regions; i++) begin : g_region
    // Valid only toward the owning region
    assign q[i].valid = q_valid[i];
    // Payload goes to every queue and valid selects
    assign q[i].data  = s_data;
    // Collect ready for the mux above
    assign q_ready[i] = q[i].ready;
  end

  // At most one region addressed per cycle
  a_one_region : assert property (
    @(posedge aclk) disable iff (!rst_n)
    $onehot0(q_valid)
  ) else $error("rx_meta_steer: more than one region valid");

  // Stalled request must not change under the upstream source
  // A withdrawn valid frees the data again
  a_stall_hold : assert property (
    @(posedge aclk) disable iff (!rst_n)
    (s_valid && !s_ready) |=> (!s_valid || $stable(s_data))
  ) else $error("rx_meta_steer: s_data changed while stalled");

endmodule

/* tb.f */
source/rdma_rx_pkg.sv
source/meta_if.sv
source/rx_meta_steer.sv
source/region_queue.sv
source/rdma_meta_rx_top.sv
dv/clk_gen.sv
dv/tb_rdma_meta_rx.sv
